// File: hdl/ipu_complex.sv
/*
 * IPU complex top
 * Offload request and response spill registers around the integer processing unit
 */
`timescale 1ns/1ns

module ipu_complex import ipu_pkg::*; #(
  parameter int unsigned IdWidth      = 5,
  parameter bit          RegisterReq  = 1'b1,
  parameter bit          RegisterResp = 1'b1
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [31:0]        acc_qdata_op_i,
  input  logic [31:0]        acc_qdata_arga_i,
  input  logic [31:0]        acc_qdata_argb_i,
  input  logic [IdWidth-1:0] acc_qid_i,
  input  logic               acc_qvalid_i,
  output logic               acc_qready_o,
  output logic [31:0]        acc_pdata_o,
  output logic [IdWidth-1:0] acc_pid_o,
  output logic               acc_perror_o,
  output logic               acc_pvalid_o,
  input  logic               acc_pready_i
);

  localparam int unsigned ReqWidth  = 3 * 32 + IdWidth;
  localparam int unsigned RespWidth = 32 + IdWidth + 1;

  // Request side
  logic [ReqWidth-1:0]  req_q_data;
  logic                 req_q_valid, req_q_ready;
  ipu_inst_u            req_op;
  logic [31:0]          req_arga, req_argb;
  logic [IdWidth-1:0]   req_id;

  // Dispatch to the units
  logic [31:0]          opa, opb;
  logic [IdWidth-1:0]   dec_id;
  logic                 mul_in_valid, mul_in_ready, div_in_valid, div_in_ready;
  ipu_mul_op_e          mul_op;
  ipu_div_op_e          div_op;
  logic                 err_valid, err_ready;

  // Unit results
  logic                 mul_valid, mul_ready, div_valid, div_ready;
  logic [31:0]          mul_data, div_data;
  logic [IdWidth-1:0]   mul_id, div_id;

  // Response side
  logic [RespWidth-1:0] resp_d_data, resp_q_data;
  logic                 resp_d_valid, resp_d_ready;
  logic [31:0]          resp_data;
  logic [IdWidth-1:0]   resp_id;
  logic                 resp_error;

  // ------------------------------
  // Request cut
  // ------------------------------
  spill_register #(
    .Width  ( ReqWidth     ),
    .Bypass ( !RegisterReq )
  ) i_spill_req (
    .clk_i   ( clk_i                                                        ),
    .rst_i   ( rst_i                                                        ),
    .valid_i ( acc_qvalid_i                                                 ),
    .ready_o ( acc_qready_o                                                 ),
    .data_i  ( {acc_qdata_op_i, acc_qdata_arga_i, acc_qdata_argb_i, acc_qid_i} ),
    .valid_o ( req_q_valid                                                  ),
    .ready_i ( req_q_ready                                                  ),
    .data_o  ( req_q_data                                                   )
  );

  assign {req_op.raw, req_arga, req_argb, req_id} = req_q_data;

  // ------------------------------
  // Processing unit
  // ------------------------------
  ipu_decode #(.IdWidth(IdWidth)) i_decode (
    .valid_i     ( req_q_valid  ), .ready_o     ( req_q_ready  ),
    .op_i        ( req_op       ), .arga_i      ( req_arga     ),
    .argb_i      ( req_argb     ), .id_i        ( req_id       ),
    .mul_valid_o ( mul_in_valid ), .mul_ready_i ( mul_in_ready ),
    .mul_op_o    ( mul_op       ), .div_valid_o ( div_in_valid ),
    .div_ready_i ( div_in_ready ), .div_op_o    ( div_op       ),
    .err_valid_o ( err_valid    ), .err_ready_i ( err_ready    ),
    .opa_o       ( opa          ), .opb_o       ( opb          ),
    .id_o        ( dec_id       )
  );

  ipu_multiplier #(.IdWidth(IdWidth)) i_multiplier (
    .clk_i   ( clk_i        ), .rst_i   ( rst_i     ),
    .valid_i ( mul_in_valid ), .ready_o ( mul_in_ready ),
    .op_i    ( mul_op       ), .opa_i   ( opa       ),
    .opb_i   ( opb          ), .id_i    ( dec_id    ),
    .valid_o ( mul_valid    ), .ready_i ( mul_ready ),
    .data_o  ( mul_data     ), .id_o    ( mul_id    )
  );

  ipu_divider #(.IdWidth(IdWidth)) i_divider (
    .clk_i   ( clk_i        ), .rst_i   ( rst_i     ),
    .valid_i ( div_in_valid ), .ready_o ( div_in_ready ),
    .op_i    ( div_op       ), .opa_i   ( opa       ),
    .opb_i   ( opb          ), .id_i    ( dec_id    ),
    .valid_o ( div_valid    ), .ready_i ( div_ready ),
    .data_o  ( div_data     ), .id_o    ( div_id    )
  );

  ipu_result #(.IdWidth(IdWidth)) i_result (
    .div_valid_i ( div_valid    ), .div_ready_o ( div_ready    ),
    .div_data_i  ( div_data     ), .div_id_i    ( div_id       ),
    .mul_valid_i ( mul_valid    ), .mul_ready_o ( mul_ready    ),
    .mul_data_i  ( mul_data     ), .mul_id_i    ( mul_id       ),
    .err_valid_i ( err_valid    ), .err_ready_o ( err_ready    ),
    .err_id_i    ( dec_id       ), .valid_o     ( resp_d_valid ),
    .ready_i     ( resp_d_ready ), .data_o      ( resp_data    ),
    .id_o        ( resp_id      ), .error_o     ( resp_error   )
  );

  // ------------------------------
  // Response cut
  // ------------------------------
  assign resp_d_data = {resp_data, resp_id, resp_error};

  spill_register #(
    .Width  ( RespWidth     ),
    .Bypass ( !RegisterResp )
  ) i_spill_resp (
    .clk_i   ( clk_i        ),
    .rst_i   ( rst_i        ),
    .valid_i ( resp_d_valid ),
    .ready_o ( resp_d_ready ),
    .data_i  ( resp_d_data  ),
    .valid_o ( acc_pvalid_o ),
    .ready_i ( acc_pready_i ),
    .data_o  ( resp_q_data  )
  );

  assign {acc_pdata_o, acc_pid_o, acc_perror_o} = resp_q_data;

endmodule

// File: hdl/ipu_decode.sv
/*
 * IPU decode
 * Classifies the offloaded word and dispatches it to multiplier, divider or error path
 */
`timescale 1ns/1ns

module ipu_decode import ipu_pkg::*; #(
  parameter int unsigned IdWidth = 5
) (
  input  logic               valid_i,
  output logic               ready_o,
  input  ipu_inst_u          op_i,
  input  logic [31:0]        arga_i,
  input  logic [31:0]        argb_i,
  input  logic [IdWidth-1:0] id_i,
  output logic               mul_valid_o,
  input  logic               mul_ready_i,
  output ipu_mul_op_e        mul_op_o,
  output logic               div_valid_o,
  input  logic               div_ready_i,
  output ipu_div_op_e        div_op_o,
  output logic               err_valid_o,
  input  logic               err_ready_i,
  output logic [31:0]        opa_o,
  output logic [31:0]        opb_o,
  output logic [IdWidth-1:0] id_o
);

  logic is_legal;
  logic is_div;

  // Only OP-class words with the M extension funct7 are handled
  assign is_legal = (op_i.rtype.opcode == OpcodeOp) && (op_i.rtype.funct7 == Funct7MulDiv);

  always_comb begin
    is_div   = 1'b0;
    mul_op_o = MulOpMul;
    div_op_o = DivOpDiv;
    unique case (op_i.rtype.funct3)
      3'd0: mul_op_o = MulOpMul;
      3'd1: mul_op_o = MulOpMulh;
      3'd2: mul_op_o = MulOpMulhsu;
      3'd3: mul_op_o = MulOpMulhu;
      3'd4: begin
        is_div   = 1'b1;
        div_op_o = DivOpDiv;
      end
      3'd5: begin
        is_div   = 1'b1;
        div_op_o = DivOpDivu;
      end
      3'd6: begin
        is_div   = 1'b1;
        div_op_o = DivOpRem;
      end
      default: begin
        is_div   = 1'b1;
        div_op_o = DivOpRemu;
      end
    endcase
  end

  // Exactly one target, and the handshake follows that target
  assign mul_valid_o = valid_i && is_legal && !is_div;
  assign div_valid_o = valid_i && is_legal && is_div;
  assign err_valid_o = valid_i && !is_legal;
  assign ready_o     = !is_legal ? err_ready_i : (is_div ? div_ready_i : mul_ready_i);

  // Shared operand bus
  assign opa_o = arga_i;
  assign opb_o = argb_i;
  assign id_o  = id_i;

endmodule

// File: hdl/ipu_divider.sv
/*
 * IPU divider
 * Iterative restoring divider for DIV, DIVU, REM and REMU with RISC-V corner cases
 */
`timescale 1ns/1ns

module ipu_divider import ipu_pkg::*; #(
  parameter int unsigned IdWidth = 5
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               valid_i,
  output logic               ready_o,
  input  ipu_div_op_e        op_i,
  input  logic [31:0]        opa_i,
  input  logic [31:0]        opb_i,
  input  logic [IdWidth-1:0] id_i,
  output logic               valid_o,
  input  logic               ready_i,
  output logic [31:0]        data_o,
  output logic [IdWidth-1:0] id_o
);

  logic               busy_q, valid_q;
  logic [5:0]         cnt_q;
  ipu_div_op_e        op_q;
  logic [IdWidth-1:0] id_q;
  logic [31:0]        quo_q, dvs_q, rem_q, res_q;
  logic               q_neg_q, r_neg_q, zero_q;
  logic               is_signed, is_rem, neg_a, neg_b;
  logic [32:0]        partial;
  logic [33:0]        diff;
  logic [31:0]        quo_fix, rem_fix;

  assign ready_o   = !busy_q && !valid_q;
  assign is_signed = (op_q == DivOpDiv) || (op_q == DivOpRem);
  assign is_rem    = (op_q == DivOpRem) || (op_q == DivOpRemu);
  assign neg_a     = is_signed && quo_q[31];
  assign neg_b     = is_signed && dvs_q[31];

  // One restoring step, borrow in the top bit
  assign partial = {rem_q, quo_q[31]};
  assign diff    = {1'b0, partial} - {2'b00, dvs_q};

  // Divide by zero forces all ones; MIN / -1 already yields MIN and 0
  assign quo_fix = zero_q ? '1 : (q_neg_q ? -quo_q : quo_q);
  assign rem_fix = r_neg_q ? -rem_q : rem_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else if (valid_i && ready_o) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 6'd1;
      if (cnt_q == 6'd33) begin
        busy_q  <= 1'b0;
        valid_q <= 1'b1;
      end
    end else if (valid_q && ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      quo_q <= opa_i;
      dvs_q <= opb_i;
      op_q  <= op_i;
      id_q  <= id_i;
    end else if (busy_q) begin
      if (cnt_q == 6'd0) begin
        // Load phase: magnitudes and result signs
        quo_q   <= neg_a ? -quo_q : quo_q;
        dvs_q   <= neg_b ? -dvs_q : dvs_q;
        rem_q   <= '0;
        q_neg_q <= neg_a ^ neg_b;
        r_neg_q <= neg_a;
        zero_q  <= (dvs_q == '0);
      end else if (cnt_q <= 6'd32) begin
        quo_q <= {quo_q[30:0], !diff[33]};
        rem_q <= diff[33] ? partial[31:0] : diff[31:0];
      end else begin
        res_q <= is_rem ? rem_fix : quo_fix;
      end
    end
  end

  assign valid_o = valid_q;
  assign data_o  = res_q;
  assign id_o    = id_q;

endmodule

// File: hdl/ipu_multiplier.sv
/*
 * IPU multiplier
 * Two-stage 33x33 signed multiplier returning the low or high product word
 */
`timescale 1ns/1ns

module ipu_multiplier import ipu_pkg::*; #(
  parameter int unsigned IdWidth = 5
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               valid_i,
  output logic               ready_o,
  input  ipu_mul_op_e        op_i,
  input  logic [31:0]        opa_i,
  input  logic [31:0]        opb_i,
  input  logic [IdWidth-1:0] id_i,
  output logic               valid_o,
  input  logic               ready_i,
  output logic [31:0]        data_o,
  output logic [IdWidth-1:0] id_o
);

  logic               stall;
  logic               sign_a, sign_b;
  logic               s1_valid_q, s2_valid_q;
  logic [32:0]        s1_opa_q, s1_opb_q;
  logic               s1_high_q, s2_high_q;
  logic [IdWidth-1:0] s1_id_q, s2_id_q;
  logic [65:0]        s2_prod_q;

  // Whole pipe freezes while the result waits
  assign stall   = s2_valid_q && !ready_i;
  assign ready_o = !stall;

  // Extra operand bit carries the sign for signed views, zero otherwise
  assign sign_a = ((op_i == MulOpMulh) || (op_i == MulOpMulhsu)) && opa_i[31];
  assign sign_b = (op_i == MulOpMulh) && opb_i[31];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (!stall) begin
      s1_valid_q <= valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      if (valid_i) begin
        s1_opa_q  <= {sign_a, opa_i};
        s1_opb_q  <= {sign_b, opb_i};
        s1_high_q <= (op_i != MulOpMul);
        s1_id_q   <= id_i;
      end
      if (s1_valid_q) begin
        s2_prod_q <= $signed(s1_opa_q) * $signed(s1_opb_q);
        s2_high_q <= s1_high_q;
        s2_id_q   <= s1_id_q;
      end
    end
  end

  assign valid_o = s2_valid_q;
  assign data_o  = s2_high_q ? s2_prod_q[63:32] : s2_prod_q[31:0];
  assign id_o    = s2_id_q;

endmodule

// File: hdl/ipu_pkg.sv
/*
 * Integer processing unit package
 * Instruction word views, unit operation encodings and opcode constants
 */
package ipu_pkg;

  // ------------------------------
  // Instruction word
  // ------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } ipu_rtype_t;

  // Raw word for transport, R-type fields for decode
  typedef union packed {
    logic [31:0] raw;
    ipu_rtype_t  rtype;
  } ipu_inst_u;

  // ------------------------------
  // Unit operations
  // ------------------------------
  // Encodings follow funct3 order within each unit
  typedef enum logic [1:0] {
    MulOpMul    = 2'd0,
    MulOpMulh   = 2'd1,
    MulOpMulhsu = 2'd2,
    MulOpMulhu  = 2'd3
  } ipu_mul_op_e;

  typedef enum logic [1:0] {
    DivOpDiv  = 2'd0,
    DivOpDivu = 2'd1,
    DivOpRem  = 2'd2,
    DivOpRemu = 2'd3
  } ipu_div_op_e;

  // Register-register major opcode and M extension funct7
  localparam logic [6:0] OpcodeOp     = 7'b0110011;
  localparam logic [6:0] Funct7MulDiv = 7'b0000001;

endpackage

// File: hdl/ipu_result.sv
/*
 * IPU result merge
 * Fixed-priority merge of divider, multiplier and error responses
 */
`timescale 1ns/1ns

module ipu_result #(
  parameter int unsigned IdWidth = 5
) (
  input  logic               div_valid_i,
  output logic               div_ready_o,
  input  logic [31:0]        div_data_i,
  input  logic [IdWidth-1:0] div_id_i,
  input  logic               mul_valid_i,
  output logic               mul_ready_o,
  input  logic [31:0]        mul_data_i,
  input  logic [IdWidth-1:0] mul_id_i,
  input  logic               err_valid_i,
  output logic               err_ready_o,
  input  logic [IdWidth-1:0] err_id_i,
  output logic               valid_o,
  input  logic               ready_i,
  output logic [31:0]        data_o,
  output logic [IdWidth-1:0] id_o,
  output logic               error_o
);

  // ------------------------------
  // Source selection
  // ------------------------------
  // Divider first, it blocks its unit the longest
  always_comb begin
    valid_o = 1'b0;
    data_o  = '0;
    id_o    = '0;
    error_o = 1'b0;
    if (div_valid_i) begin
      valid_o = 1'b1;
      data_o  = div_data_i;
      id_o    = div_id_i;
    end else if (mul_valid_i) begin
      valid_o = 1'b1;
      data_o  = mul_data_i;
      id_o    = mul_id_i;
    end else if (err_valid_i) begin
      valid_o = 1'b1;
      id_o    = err_id_i;
      error_o = 1'b1;
    end
  end

  // ------------------------------
  // Back-pressure
  // ------------------------------
  // Lower sources stall while a higher one is presenting
  assign div_ready_o = ready_i;
  assign mul_ready_o = ready_i && !div_valid_i;
  assign err_ready_o = ready_i && !div_valid_i && !mul_valid_i;

endmodule

// File: hdl/spill_register.sv
/*
 * Valid/ready spill register
 * Two-entry slice that cuts valid, ready and data paths, or plain wires
 */
`timescale 1ns/1ns

module spill_register #(
  parameter int unsigned Width  = 32,
  parameter bit          Bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    logic             a_full_q, b_full_q;
    logic [Width-1:0] a_data_q, b_data_q;
    logic             a_fill, a_drain, b_fill, b_drain;

    // Slot A takes new items, slot B catches A when the output stalls
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Older item sits in B whenever B is occupied
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
  end

endmodule

// File: tb.f
+incdir+verification
hdl/ipu_pkg.sv
hdl/spill_register.sv
hdl/ipu_decode.sv
hdl/ipu_multiplier.sv
hdl/ipu_divider.sv
hdl/ipu_result.sv
hdl/ipu_complex.sv
verification/ipu_complex_tb.sv

// File: verification/ipu_tests.svh
/*
 * IPU directed tests
 * Reset, arithmetic, illegal word, reordering and back-pressure scenarios
 */

task automatic check_reset_state();
  checks += 2;
  if (acc_pvalid_o !== 1'b0) begin
    $display("[FAIL] acc_pvalid_o after reset: expected %h, got %h", 1'b0, acc_pvalid_o);
    errors++;
  end
  if (acc_qready_o !== 1'b1) begin
    $display("[FAIL] acc_qready_o after reset: expected %h, got %h", 1'b1, acc_qready_o);
    errors++;
  end
endtask

// Five corner pairs then three random pairs per operation
task automatic run_multiplies();
  logic [31:0] edge_a [5];
  logic [31:0] edge_b [5];
  logic [31:0] a;
  logic [31:0] b;
  edge_a = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'hffff_ffff};
  edge_b = '{32'h1234_5678, 32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
  clear_tables();
  for (int f3 = 0; f3 < 4; f3++) begin
    for (int k = 0; k < 8; k++) begin
      a = (k < 5) ? edge_a[k] : $random(seed);
      b = (k < 5) ? edge_b[k] : $random(seed);
      send_req(make_inst(Funct7M, f3[2:0], OpcodeRr), a, b, f3 * 8 + k);
    end
  end
  wait_responses(RespLimit);
  check_responses();
endtask

// Divide by zero, MIN / -1 and mixed signs before the random pairs
task automatic run_divisions();
  logic [31:0] edge_a [5];
  logic [31:0] edge_b [5];
  logic [31:0] a;
  logic [31:0] b;
  edge_a = '{32'h1234_5678, 32'h8000_0000, 32'h0, 32'hffff_fff9, 32'h7};
  edge_b = '{32'h0, 32'hffff_ffff, 32'h0, 32'h2, 32'hffff_fffe};
  clear_tables();
  for (int f3 = 4; f3 < 8; f3++) begin
    for (int k = 0; k < 8; k++) begin
      a = (k < 5) ? edge_a[k] : $random(seed);
      b = (k < 5) ? edge_b[k] : $random(seed);
      send_req(make_inst(Funct7M, f3[2:0], OpcodeRr), a, b, (f3 - 4) * 8 + k);
    end
  end
  wait_responses(RespLimit);
  check_responses();
endtask

task automatic send_illegal_words();
  clear_tables();
  send_req(make_inst(Funct7M, 3'd0, 7'b0010011), 32'd5, 32'd6, 7);
  send_req(make_inst(7'b0000000, 3'd0, OpcodeRr), 32'd5, 32'd6, 8);
  send_req(make_inst(7'b0100000, 3'd4, OpcodeRr), 32'd9, 32'd3, 9);
  send_req(make_inst(Funct7M, 3'd1, 7'b1110011), 32'd9, 32'd3, 10);
  // Legal multiply in between
  send_req(make_inst(Funct7M, 3'd0, OpcodeRr), 32'd5, 32'd6, 11);
  send_req(32'hffff_ffff, 32'd1, 32'd1, 12);
  wait_responses(RespLimit);
  check_responses();
endtask

task automatic check_div_mul_order();
  clear_tables();
  send_req(make_inst(Funct7M, 3'd4, OpcodeRr), 32'd1000, 32'd7, 3);
  send_req(make_inst(Funct7M, 3'd0, OpcodeRr), 32'd1000, 32'd7, 4);
  wait_responses(RespLimit);
  check_responses();
  checks++;
  if (got[3] && got[4] && (got_seq[4] > got_seq[3])) begin
    $display("MUL with id 4 returned after the DIV with id 3");
    errors++;
  end
endtask

task automatic stream_under_backpressure();
  logic [31:0] insts [NumIds];
  logic [31:0] args_a [NumIds];
  logic [31:0] args_b [NumIds];
  logic [31:0] rnd;
  logic [6:0]  funct7;
  logic [2:0]  funct3;
  logic        stream_done;
  int          cycles;
  clear_tables();
  // Stream drawn up front so that ready toggling alone draws from the seed
  for (int i = 0; i < NumIds; i++) begin
    funct7    = (($random(seed) & 7) == 0) ? 7'b0000000 : Funct7M;
    rnd       = $random(seed);
    funct3    = rnd[2:0];
    insts[i]  = make_inst(funct7, funct3, OpcodeRr);
    args_a[i] = $random(seed);
    args_b[i] = (($random(seed) & 15) == 0) ? 32'h0 : $random(seed);
  end
  stream_done = 1'b0;
  cycles      = 0;
  fork
    begin
      for (int i = 0; i < NumIds; i++) begin
        send_req(insts[i], args_a[i], args_b[i], i);
      end
      wait_responses(RespLimit);
      stream_done = 1'b1;
    end
    begin
      while (!stream_done && cycles < 4 * RespLimit) begin
        acc_pready_i = ($random(seed) & 1) == 1;
        wait_edge();
        cycles++;
      end
    end
  join
  acc_pready_i = 1'b1;
  check_responses();
endtask

// File: verification/ipu_complex_tb.sv
/*
 * IPU complex testbench
 * Plays the core side of the offload port and checks tagged responses
 */
`timescale 1ns/1ns

module ipu_complex_tb;

  localparam int IdWidth   = 5;
  localparam int NumIds    = 1 << IdWidth;
  localparam int ReqLimit  = 200;
  localparam int RespLimit = 4000;

  // M extension encoding of register-register operations
  localparam logic [6:0] OpcodeRr = 7'b0110011;
  localparam logic [6:0] Funct7M  = 7'b0000001;

  logic               clk_i;
  logic               rst_i;
  logic [31:0]        acc_qdata_op_i;
  logic [31:0]        acc_qdata_arga_i;
  logic [31:0]        acc_qdata_argb_i;
  logic [IdWidth-1:0] acc_qid_i;
  logic               acc_qvalid_i;
  logic               acc_qready_o;
  logic [31:0]        acc_pdata_o;
  logic [IdWidth-1:0] acc_pid_o;
  logic               acc_perror_o;
  logic               acc_pvalid_o;
  logic               acc_pready_i;

  // Per-id expectation and response tables
  logic        sent [NumIds];
  logic        got [NumIds];
  logic [31:0] exp_data [NumIds];
  logic        exp_err [NumIds];
  logic [31:0] got_data [NumIds];
  logic        got_err [NumIds];
  int          got_seq [NumIds];
  int          resp_count;
  int          checks;
  int          errors;
  int          seed;

  ipu_complex #(
    .IdWidth      ( IdWidth ),
    .RegisterReq  ( 1'b1    ),
    .RegisterResp ( 1'b1    )
  ) ipu_complex_i (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .acc_qdata_op_i   ( acc_qdata_op_i   ),
    .acc_qdata_arga_i ( acc_qdata_arga_i ),
    .acc_qdata_argb_i ( acc_qdata_argb_i ),
    .acc_qid_i        ( acc_qid_i        ),
    .acc_qvalid_i     ( acc_qvalid_i     ),
    .acc_qready_o     ( acc_qready_o     ),
    .acc_pdata_o      ( acc_pdata_o      ),
    .acc_pid_o        ( acc_pid_o        ),
    .acc_perror_o     ( acc_perror_o     ),
    .acc_pvalid_o     ( acc_pvalid_o     ),
    .acc_pready_i     ( acc_pready_i     )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ------------------------------
  // Monitor
  // ------------------------------
  // Mid-cycle sample of a transfer that completes on the next rising edge
  always @(negedge clk_i) begin
    if (!rst_i && acc_pvalid_o && acc_pready_i) begin
      if (!sent[acc_pid_o]) begin
        $display("Unexpected response with id %0d", acc_pid_o);
        errors++;
      end else if (got[acc_pid_o]) begin
        $display("Duplicate response for id %0d", acc_pid_o);
        errors++;
      end else begin
        got[acc_pid_o]      = 1'b1;
        got_data[acc_pid_o] = acc_pdata_o;
        got_err[acc_pid_o]  = acc_perror_o;
        got_seq[acc_pid_o]  = resp_count;
      end
      resp_count++;
    end
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  // Expected {error, data} from the M extension rules
  function automatic logic [32:0] model_result(input logic [31:0] inst, input logic [31:0] a,
                                               input logic [31:0] b);
    logic [63:0]        prod;
    logic [31:0]        res;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] squo;
    logic signed [31:0] srem;
    logic               overflow;
    sa       = a;
    sb       = b;
    squo     = '0;
    srem     = '0;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    if ((inst[6:0] != OpcodeRr) || (inst[31:25] != Funct7M)) begin
      return {1'b1, 32'h0};
    end
    // Signed quotient and remainder only where both are defined
    if ((b != 0) && !overflow) begin
      squo = sa / sb;
      srem = sa % sb;
    end
    case (inst[14:12])
      3'd0: res = a * b;
      3'd1: begin
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        res  = prod[63:32];
      end
      3'd2: begin
        prod = {{32{a[31]}}, a} * {32'h0, b};
        res  = prod[63:32];
      end
      3'd3: begin
        prod = {32'h0, a} * {32'h0, b};
        res  = prod[63:32];
      end
      3'd4: res = (b == 0) ? 32'hffff_ffff : (overflow ? a : squo);
      3'd5: res = (b == 0) ? 32'hffff_ffff : a / b;
      3'd6: res = (b == 0) ? a : (overflow ? 32'h0 : srem);
      default: res = (b == 0) ? a : a % b;
    endcase
    return {1'b0, res};
  endfunction

  function automatic logic [31:0] make_inst(input logic [6:0] funct7, input logic [2:0] funct3,
                                            input logic [6:0] opcode);
    return {funct7, 5'd2, 5'd1, funct3, 5'd3, opcode};
  endfunction

  // ------------------------------
  // Driver and scoreboard
  // ------------------------------
  task automatic wait_edge();
    @(posedge clk_i);
    #1;
  endtask

  task automatic clear_tables();
    for (int i = 0; i < NumIds; i++) begin
      sent[i] = 1'b0;
      got[i]  = 1'b0;
    end
  endtask

  task automatic send_req(input logic [31:0] inst, input logic [31:0] a, input logic [31:0] b,
                          input int id);
    logic [32:0] expected;
    logic        accepted;
    int          cycles;
    expected         = model_result(inst, a, b);
    exp_err[id]      = expected[32];
    exp_data[id]     = expected[31:0];
    sent[id]         = 1'b1;
    accepted         = 1'b0;
    cycles           = 0;
    acc_qdata_op_i   = inst;
    acc_qdata_arga_i = a;
    acc_qdata_argb_i = b;
    acc_qid_i        = id[IdWidth-1:0];
    acc_qvalid_i     = 1'b1;
    while (!accepted && cycles < ReqLimit) begin
      #2;
      accepted = acc_qready_o;
      wait_edge();
      cycles++;
    end
    acc_qvalid_i = 1'b0;
    if (!accepted) begin
      $display("Timeout: request id %0d was not accepted", id);
      errors++;
    end
  endtask

  task automatic wait_responses(input int limit);
    logic all_done;
    int   cycles;
    all_done = 1'b0;
    cycles   = 0;
    while (!all_done && cycles < limit) begin
      wait_edge();
      cycles++;
      all_done = 1'b1;
      for (int i = 0; i < NumIds; i++) begin
        if (sent[i] && !got[i]) begin
          all_done = 1'b0;
        end
      end
    end
    if (!all_done) begin
      $display("Timeout: responses still missing after %0d cycles", limit);
      errors++;
    end
  endtask

  task automatic check_responses();
    for (int i = 0; i < NumIds; i++) begin
      if (sent[i] && !got[i]) begin
        $display("No response received for id %0d", i);
        errors++;
      end else if (sent[i]) begin
        checks += 2;
        if (got_data[i] !== exp_data[i]) begin
          $display("[FAIL] acc_pdata_o id %0d: expected %h, got %h", i, exp_data[i], got_data[i]);
          errors++;
        end
        if (got_err[i] !== exp_err[i]) begin
          $display("[FAIL] acc_perror_o id %0d: expected %h, got %h", i, exp_err[i], got_err[i]);
          errors++;
        end
      end
    end
  endtask

  `include "ipu_tests.svh"

  initial begin
    seed             = 79994;
    errors           = 0;
    checks           = 0;
    resp_count       = 0;
    rst_i            = 1'b1;
    acc_qdata_op_i   = '0;
    acc_qdata_arga_i = '0;
    acc_qdata_argb_i = '0;
    acc_qid_i        = '0;
    acc_qvalid_i     = 1'b0;
    acc_pready_i     = 1'b1;
    clear_tables();
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_reset_state();
    run_multiplies();
    run_divisions();
    send_illegal_words();
    check_div_mul_order();
    stream_under_backpressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
